// File: src/exu_pkg.sv
package exu_pkg;

    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;
    localparam int reg_num    = 32;
    localparam int mask_w     = xlen / 8;

    // abi register a0 carries the ebreak code
    localparam logic [reg_addr_w-1:0] reg_a0 = 5'd10;

    typedef enum logic [5:0] {
        op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_sra, op_slt, op_sltu, op_mul,
        op_addi, op_andi, op_ori, op_xori, op_slli, op_srli, op_srai, op_slti,
        op_addw, op_subw, op_sllw, op_srlw, op_sraw, op_addiw, op_mulw,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld,
        op_sb, op_sh, op_sw, op_sd,
        op_ebreak, op_nop
    } exu_op_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu, alu_mul
    } alu_mode_e;

    typedef enum logic [1:0] {a_rs1, a_pc, a_zero} a_sel_e;
    typedef enum logic {b_rs2, b_imm} b_sel_e;
    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4, wb_imm} wb_sel_e;
    typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_kind_e;
    typedef enum logic [1:0] {size_b, size_h, size_w, size_d} mem_size_e;
    typedef enum logic [1:0] {pc_seq, pc_jal, pc_jalr, pc_branch} pc_kind_e;
    typedef enum logic [2:0] {br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu} br_cond_e;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        exu_op_e               op;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       imm;
    } exu_inst_t;

    typedef struct packed {
        a_sel_e    a_sel;
        b_sel_e    b_sel;
        alu_mode_e alu_mode;
        logic      word;
        wb_sel_e   wb_sel;
        logic      reg_we;
        mem_kind_e mem_kind;
        mem_size_e mem_size;
        logic      mem_signed;
        pc_kind_e  pc_kind;
        br_cond_e  br_cond;
        logic      halt;
    } exu_ctrl_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } exu_wb_t;

endpackage

// File: src/exu_ctrl.sv
`timescale 1ns/1ns

module exu_ctrl import exu_pkg::*; (
    input  exu_op_e   op,
    output exu_ctrl_t ctrl
);

    always_comb begin
        ctrl.a_sel      = a_rs1;
        ctrl.b_sel      = b_rs2;
        ctrl.alu_mode   = alu_add;
        ctrl.word       = op inside {op_addw, op_subw, op_sllw, op_srlw, op_sraw,
                                     op_addiw, op_mulw};
        ctrl.wb_sel     = wb_alu;
        ctrl.reg_we     = 1'b0;
        ctrl.mem_kind   = mem_none;
        ctrl.mem_size   = size_d;
        ctrl.mem_signed = op inside {op_lb, op_lh, op_lw};
        ctrl.pc_kind    = pc_seq;
        ctrl.br_cond    = br_eq;
        ctrl.halt       = 1'b0;

        // instruction class
        unique case (op)
            op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_sra, op_slt, op_sltu,
            op_mul, op_addw, op_subw, op_sllw, op_srlw, op_sraw, op_mulw: begin
                ctrl.reg_we = 1'b1;
            end
            op_addi, op_andi, op_ori, op_xori, op_slli, op_srli, op_srai, op_slti,
            op_addiw: begin
                ctrl.b_sel  = b_imm;
                ctrl.reg_we = 1'b1;
            end
            op_lui: begin
                ctrl.a_sel  = a_zero;
                ctrl.b_sel  = b_imm;
                ctrl.wb_sel = wb_imm;
                ctrl.reg_we = 1'b1;
            end
            op_auipc: begin
                ctrl.a_sel  = a_pc;
                ctrl.b_sel  = b_imm;
                ctrl.reg_we = 1'b1;
            end
            op_jal: begin
                ctrl.a_sel   = a_pc;
                ctrl.b_sel   = b_imm;
                ctrl.wb_sel  = wb_pc4;
                ctrl.reg_we  = 1'b1;
                ctrl.pc_kind = pc_jal;
            end
            op_jalr: begin
                ctrl.b_sel   = b_imm;
                ctrl.wb_sel  = wb_pc4;
                ctrl.reg_we  = 1'b1;
                ctrl.pc_kind = pc_jalr;
            end
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                ctrl.pc_kind  = pc_branch;
                ctrl.alu_mode = (op inside {op_bltu, op_bgeu}) ? alu_sltu : alu_sub;
            end
            op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld: begin
                ctrl.b_sel    = b_imm;
                ctrl.wb_sel   = wb_mem;
                ctrl.reg_we   = 1'b1;
                ctrl.mem_kind = mem_load;
            end
            op_sb, op_sh, op_sw, op_sd: begin
                ctrl.b_sel    = b_imm;
                ctrl.mem_kind = mem_store;
            end
            op_ebreak: begin
                ctrl.a_sel = a_zero;
                ctrl.halt  = 1'b1;
            end
            default: ctrl.a_sel = a_zero;
        endcase

        // alu function, branch condition and access size
        unique case (op)
            op_sub, op_subw:          ctrl.alu_mode = alu_sub;
            op_and, op_andi:          ctrl.alu_mode = alu_and;
            op_or, op_ori:            ctrl.alu_mode = alu_or;
            op_xor, op_xori:          ctrl.alu_mode = alu_xor;
            op_sll, op_slli, op_sllw: ctrl.alu_mode = alu_sll;
            op_srl, op_srli, op_srlw: ctrl.alu_mode = alu_srl;
            op_sra, op_srai, op_sraw: ctrl.alu_mode = alu_sra;
            op_slt, op_slti:          ctrl.alu_mode = alu_slt;
            op_sltu:                  ctrl.alu_mode = alu_sltu;
            op_mul, op_mulw:          ctrl.alu_mode = alu_mul;
            op_bne:                   ctrl.br_cond  = br_ne;
            op_blt:                   ctrl.br_cond  = br_lt;
            op_bge:                   ctrl.br_cond  = br_ge;
            op_bltu:                  ctrl.br_cond  = br_ltu;
            op_bgeu:                  ctrl.br_cond  = br_geu;
            op_lb, op_lbu, op_sb:     ctrl.mem_size = size_b;
            op_lh, op_lhu, op_sh:     ctrl.mem_size = size_h;
            op_lw, op_lwu, op_sw:     ctrl.mem_size = size_w;
            default: ;
        endcase
    end

endmodule

// File: src/exu_regfile.sv
`timescale 1ns/1ns

module exu_regfile import exu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,
    input  logic                  we
);

    logic [xlen-1:0] regs [reg_num];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_num; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: src/exu_alu.sv
`timescale 1ns/1ns

module exu_alu import exu_pkg::*; (
    input  alu_mode_e       mode,
    input  logic            word,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result,
    output logic            zero,
    output logic            lt,
    output logic            ltu
);

    logic [xlen-1:0] a_ext;
    logic [5:0]      shamt;
    logic [xlen-1:0] raw;

    // right shifts in word mode only see the low half of a
    always_comb begin
        if (!word) begin
            a_ext = a;
        end else if (mode == alu_sra) begin
            a_ext = {{32{a[31]}}, a[31:0]};
        end else begin
            a_ext = {32'b0, a[31:0]};
        end
    end

    assign shamt = word ? {1'b0, b[4:0]} : b[5:0];

    assign lt  = $signed(a) < $signed(b);
    assign ltu = a < b;

    always_comb begin
        unique case (mode)
            alu_add:  raw = a_ext + b;
            alu_sub:  raw = a_ext - b;
            alu_and:  raw = a_ext & b;
            alu_or:   raw = a_ext | b;
            alu_xor:  raw = a_ext ^ b;
            alu_sll:  raw = a_ext << shamt;
            alu_srl:  raw = a_ext >> shamt;
            alu_sra:  raw = $signed(a_ext) >>> shamt;
            alu_slt:  raw = {{(xlen-1){1'b0}}, lt};
            alu_sltu: raw = {{(xlen-1){1'b0}}, ltu};
            alu_mul:  raw = a_ext * b;
            default:  raw = '0;
        endcase
    end

    assign result = word ? {{32{raw[31]}}, raw[31:0]} : raw;
    assign zero   = (result == '0);

endmodule

// File: src/exu_lsu_align.sv
`timescale 1ns/1ns

module exu_lsu_align import exu_pkg::*; (
    input  exu_ctrl_t         ctrl,
    input  logic              valid,
    input  logic [xlen-1:0]   addr,
    input  logic [xlen-1:0]   store_src,
    input  logic [xlen-1:0]   mem_rdata,
    output logic [xlen-1:0]   mem_raddr,
    output logic              mem_ren,
    output logic [xlen-1:0]   mem_waddr,
    output logic [xlen-1:0]   mem_wdata,
    output logic [mask_w-1:0] mem_wmask,
    output logic              mem_wen,
    output logic [xlen-1:0]   load_data
);

    logic [2:0]        offset;
    logic [5:0]        lane_shift;
    logic [xlen-1:0]   st_val;
    logic [mask_w-1:0] size_mask;
    logic [xlen-1:0]   ld_lane;
    logic              is_store;

    assign offset     = addr[2:0];
    assign lane_shift = {offset, 3'b000};
    assign is_store   = (ctrl.mem_kind == mem_store);

    // store value trimmed to size, before lane shift
    always_comb begin
        unique case (ctrl.mem_size)
            size_b: begin
                st_val    = {56'b0, store_src[7:0]};
                size_mask = 8'h01;
            end
            size_h: begin
                st_val    = {48'b0, store_src[15:0]};
                size_mask = 8'h03;
            end
            size_w: begin
                st_val    = {32'b0, store_src[31:0]};
                size_mask = 8'h0f;
            end
            default: begin
                st_val    = store_src;
                size_mask = 8'hff;
            end
        endcase
    end

    assign mem_waddr = addr;
    assign mem_wdata = st_val << lane_shift;
    assign mem_wmask = is_store ? (size_mask << offset) : '0;
    assign mem_wen   = valid && is_store;

    assign mem_raddr = addr;
    assign mem_ren   = valid && (ctrl.mem_kind == mem_load);

    // lane moved down to bit 0
    assign ld_lane = mem_rdata >> lane_shift;

    always_comb begin
        unique case (ctrl.mem_size)
            size_b: load_data = {{56{ctrl.mem_signed & ld_lane[7]}}, ld_lane[7:0]};
            size_h: load_data = {{48{ctrl.mem_signed & ld_lane[15]}}, ld_lane[15:0]};
            size_w: load_data = {{32{ctrl.mem_signed & ld_lane[31]}}, ld_lane[31:0]};
            default: load_data = ld_lane;
        endcase
    end

endmodule

// File: src/exu_npc.sv
`timescale 1ns/1ns

module exu_npc import exu_pkg::*; (
    input  exu_ctrl_t       ctrl,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] alu_result,
    input  logic            zero,
    input  logic            lt,
    input  logic            ltu,
    output logic [xlen-1:0] dnpc
);

    logic            taken;
    logic [xlen-1:0] snpc;
    logic [xlen-1:0] tnpc;

    assign snpc = pc + 64'd4;
    assign tnpc = pc + imm;

    always_comb begin
        unique case (ctrl.br_cond)
            br_eq:   taken = zero;
            br_ne:   taken = !zero;
            br_lt:   taken = lt;
            br_ge:   taken = !lt;
            br_ltu:  taken = ltu;
            br_geu:  taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        unique case (ctrl.pc_kind)
            pc_jal:    dnpc = tnpc;
            pc_jalr:   dnpc = {alu_result[xlen-1:1], 1'b0};
            pc_branch: dnpc = taken ? tnpc : snpc;
            default:   dnpc = snpc;
        endcase
    end

endmodule

// File: src/exu_top.sv
`timescale 1ns/1ns

module exu_top import exu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  exu_inst_t         inst,
    input  logic [xlen-1:0]   mem_rdata,
    output logic [xlen-1:0]   dnpc,
    output exu_wb_t           wb,
    output logic              halt,
    output logic              halt_code,
    output logic [xlen-1:0]   mem_raddr,
    output logic              mem_ren,
    output logic [xlen-1:0]   mem_waddr,
    output logic [xlen-1:0]   mem_wdata,
    output logic [mask_w-1:0] mem_wmask,
    output logic              mem_wen
);

    exu_ctrl_t             ctrl;
    logic                  live;
    logic [reg_addr_w-1:0] raddr1;
    logic [xlen-1:0]       src1;
    logic [xlen-1:0]       src2;
    logic [xlen-1:0]       op_a;
    logic [xlen-1:0]       op_b;
    logic [xlen-1:0]       alu_result;
    logic                  alu_zero;
    logic                  alu_lt;
    logic                  alu_ltu;
    logic [xlen-1:0]       load_data;
    logic [xlen-1:0]       wb_data;

    // nothing retires once halted
    assign live = inst.valid && !halt;

    exu_ctrl u_ctrl (
        .op   (inst.op),
        .ctrl (ctrl)
    );

    // ebreak borrows read port 1 for a0
    assign raddr1 = ctrl.halt ? reg_a0 : inst.rs1;

    exu_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (raddr1),
        .raddr2 (inst.rs2),
        .rdata1 (src1),
        .rdata2 (src2),
        .waddr  (wb.rd),
        .wdata  (wb.data),
        .we     (wb.en)
    );

    always_comb begin
        unique case (ctrl.a_sel)
            a_rs1:   op_a = src1;
            a_pc:    op_a = inst.pc;
            default: op_a = '0;
        endcase
    end

    assign op_b = (ctrl.b_sel == b_imm) ? inst.imm : src2;

    exu_alu u_alu (
        .mode   (ctrl.alu_mode),
        .word   (ctrl.word),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result),
        .zero   (alu_zero),
        .lt     (alu_lt),
        .ltu    (alu_ltu)
    );

    exu_lsu_align u_lsu (
        .ctrl      (ctrl),
        .valid     (live),
        .addr      (alu_result),
        .store_src (src2),
        .mem_rdata (mem_rdata),
        .mem_raddr (mem_raddr),
        .mem_ren   (mem_ren),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wmask (mem_wmask),
        .mem_wen   (mem_wen),
        .load_data (load_data)
    );

    exu_npc u_npc (
        .ctrl       (ctrl),
        .pc         (inst.pc),
        .imm        (inst.imm),
        .alu_result (alu_result),
        .zero       (alu_zero),
        .lt         (alu_lt),
        .ltu        (alu_ltu),
        .dnpc       (dnpc)
    );

    always_comb begin
        unique case (ctrl.wb_sel)
            wb_mem:  wb_data = load_data;
            wb_pc4:  wb_data = inst.pc + 64'd4;
            wb_imm:  wb_data = inst.imm;
            default: wb_data = alu_result;
        endcase
    end

    assign wb.en   = live && ctrl.reg_we && (inst.rd != '0);
    assign wb.rd   = inst.rd;
    assign wb.data = wb_data;

    // sticky until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halt      <= 1'b0;
            halt_code <= 1'b0;
        end else if (live && ctrl.halt) begin
            halt      <= 1'b1;
            halt_code <= (src1 != '0);
        end
    end

endmodule

// File: verif/exu_checker.sv
`timescale 1ns/1ns

module exu_checker import exu_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              mem_wen,
    input logic              mem_ren,
    input logic [mask_w-1:0] mem_wmask,
    input logic              halt,
    input logic              wb_en,
    input mem_size_e         mem_size,
    input logic [xlen-1:0]   addr
);

    logic [3:0] span_end;

    // byte offset just past the access
    assign span_end = {1'b0, addr[2:0]} + (4'd1 << mem_size);

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_wen && mem_ren))
        else $error("memory read and write enabled in the same cycle");

    a_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wen |-> mem_wmask != '0)
        else $error("memory write with an empty byte mask");

    a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        halt |-> !mem_wen && !wb_en)
        else $error("write while halted");

    a_no_cross: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_wen || mem_ren) |-> span_end <= 4'd8)
        else $error("access crosses a doubleword boundary");

endmodule

bind exu_top exu_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_wen   (mem_wen),
    .mem_ren   (mem_ren),
    .mem_wmask (mem_wmask),
    .halt      (halt),
    .wb_en     (wb.en),
    .mem_size  (ctrl.mem_size),
    .addr      (alu_result)
);

// File: verif/exu_tb.sv
`timescale 1ns/1ns

module exu_tb import exu_pkg::*; ();

    localparam int seed      = 42175;
    localparam int n_alu     = 200;
    localparam int n_branch  = 100;
    localparam int mem_words = 256;
    // reset plus issue slots of all tests
    localparam int run_cycles  = 16 + (31 + n_alu + 1) + 10 + (n_branch + 1) + 45 + 43 + 50;
    localparam int cycle_limit = 2 * run_cycles + 100;

    typedef struct packed {
        logic [xlen-1:0]   dnpc;
        logic              wb_en;
        logic [xlen-1:0]   wb_data;
        logic              ld_en;
        logic [xlen-1:0]   ld_addr;
        logic              st_en;
        logic [xlen-1:0]   st_addr;
        logic [xlen-1:0]   st_data;
        logic [mask_w-1:0] st_mask;
    } exp_t;

    logic              clk;
    logic              rst_n;
    exu_inst_t         inst;
    logic [xlen-1:0]   mem_rdata;
    logic [xlen-1:0]   dnpc;
    exu_wb_t           wb;
    logic              halt;
    logic              halt_code;
    logic [xlen-1:0]   mem_raddr;
    logic              mem_ren;
    logic [xlen-1:0]   mem_waddr;
    logic [xlen-1:0]   mem_wdata;
    logic [mask_w-1:0] mem_wmask;
    logic              mem_wen;

    logic [xlen-1:0] ext_mem [mem_words];
    logic [xlen-1:0] ref_mem [mem_words];
    logic [xlen-1:0] ref_regs [32];
    logic            ref_halt;
    logic            ref_code;
    exp_t            exp_q;
    int              cycles;
    int              checks;
    int              errors;
    int              test_checks;
    int              test_errors;
    int              tests_done;

    exu_op_e alu_ops [28] = '{op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_sra,
        op_slt, op_sltu, op_mul, op_addi, op_andi, op_ori, op_xori, op_slli, op_srli, op_srai,
        op_slti, op_addw, op_subw, op_sllw, op_srlw, op_sraw, op_addiw, op_mulw, op_lui,
        op_auipc};
    exu_op_e br_ops [8] = '{op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu, op_jal, op_jalr};
    exu_op_e st_ops [4] = '{op_sb, op_sh, op_sw, op_sd};
    int      st_bytes [4] = '{1, 2, 4, 8};
    exu_op_e ld_ops [7] = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
    int      ld_bytes [7] = '{1, 1, 2, 2, 4, 4, 8};

    exu_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst      (inst),
        .mem_rdata (mem_rdata),
        .dnpc      (dnpc),
        .wb        (wb),
        .halt      (halt),
        .halt_code (halt_code),
        .mem_raddr (mem_raddr),
        .mem_ren   (mem_ren),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wmask (mem_wmask),
        .mem_wen   (mem_wen)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // data memory seen by the DUT
    assign mem_rdata = ext_mem[mem_raddr[10:3]];

    always @(posedge clk) begin
        if (mem_wen) begin
            for (int k = 0; k < mask_w; k++) begin
                if (mem_wmask[k]) begin
                    ext_mem[mem_waddr[10:3]][8*k +: 8] <= mem_wdata[8*k +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [xlen-1:0] rand64();
        return {$urandom(), $urandom()};
    endfunction

    function automatic logic [4:0] rand_reg(input int lo);
        return 5'($urandom_range(31, lo));
    endfunction

    function automatic exu_inst_t idle_inst();
        exu_inst_t x;
        x = '0;
        x.op = op_nop;
        return x;
    endfunction

    function automatic logic [xlen-1:0] alu_ref(input exu_op_e op, input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        logic            w;
        int              sh;
        logic [xlen-1:0] r;
        w  = op inside {op_addw, op_subw, op_sllw, op_srlw, op_sraw, op_addiw, op_mulw};
        sh = w ? int'(b[4:0]) : int'(b[5:0]);
        case (op)
            op_sub, op_subw:          r = a - b;
            op_and, op_andi:          r = a & b;
            op_or, op_ori:            r = a | b;
            op_xor, op_xori:          r = a ^ b;
            op_sll, op_slli, op_sllw: r = a << sh;
            op_srl, op_srli:          r = a >> sh;
            op_srlw:                  r = {32'b0, a[31:0]} >> sh;
            op_sra, op_srai:          r = $signed(a) >>> sh;
            op_sraw:                  r = $signed({{32{a[31]}}, a[31:0]}) >>> sh;
            op_slt, op_slti:          r = {63'b0, $signed(a) < $signed(b)};
            op_sltu:                  r = {63'b0, a < b};
            op_mul, op_mulw:          r = a * b;
            default:                  r = a + b;
        endcase
        if (w) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        return r;
    endfunction

    function automatic logic branch_taken(input exu_op_e op, input logic [xlen-1:0] a,
                                          input logic [xlen-1:0] b);
        case (op)
            op_beq:  return a == b;
            op_bne:  return a != b;
            op_blt:  return $signed(a) < $signed(b);
            op_bge:  return $signed(a) >= $signed(b);
            op_bltu: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [xlen-1:0] load_ref(input exu_op_e op, input logic [xlen-1:0] m,
                                                 input logic [2:0] off);
        logic [xlen-1:0] lane;
        lane = m >> (8 * off);
        case (op)
            op_lb:   return {{56{lane[7]}}, lane[7:0]};
            op_lbu:  return {56'b0, lane[7:0]};
            op_lh:   return {{48{lane[15]}}, lane[15:0]};
            op_lhu:  return {48'b0, lane[15:0]};
            op_lw:   return {{32{lane[31]}}, lane[31:0]};
            op_lwu:  return {32'b0, lane[31:0]};
            default: return lane;
        endcase
    endfunction

    // expected outputs of one instruction against the model state
    function automatic exp_t ref_exec(input exu_inst_t i);
        exp_t              e;
        logic [xlen-1:0]   a;
        logic [xlen-1:0]   b;
        logic [xlen-1:0]   bv;
        logic [xlen-1:0]   addr;
        logic [xlen-1:0]   keep;
        logic [mask_w-1:0] bm;
        logic              we;
        logic              live;
        a    = (i.op == op_ebreak) ? ref_regs[reg_a0] : ref_regs[i.rs1];
        b    = ref_regs[i.rs2];
        bv   = (i.op inside {op_addi, op_andi, op_ori, op_xori, op_slli, op_srli, op_srai,
                             op_slti, op_addiw}) ? i.imm : b;
        addr = a + i.imm;
        live = i.valid && !ref_halt;
        we   = 1'b0;
        e    = '0;
        e.dnpc = i.pc + 64'd4;
        case (i.op)
            op_lui: begin
                e.wb_data = i.imm;
                we = 1'b1;
            end
            op_auipc: begin
                e.wb_data = i.pc + i.imm;
                we = 1'b1;
            end
            op_jal, op_jalr: begin
                e.wb_data = i.pc + 64'd4;
                e.dnpc = (i.op == op_jal) ? i.pc + i.imm : (addr & ~64'd1);
                we = 1'b1;
            end
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                if (branch_taken(i.op, a, b)) begin
                    e.dnpc = i.pc + i.imm;
                end
            end
            op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld: begin
                e.wb_data = load_ref(i.op, ref_mem[addr[10:3]], addr[2:0]);
                e.ld_en   = live;
                e.ld_addr = addr;
                we = 1'b1;
            end
            op_sb, op_sh, op_sw, op_sd: begin
                case (i.op)
                    op_sb:   bm = 8'h01;
                    op_sh:   bm = 8'h03;
                    op_sw:   bm = 8'h0f;
                    default: bm = 8'hff;
                endcase
                for (int k = 0; k < mask_w; k++) begin
                    keep[8*k +: 8] = {8{bm[k]}};
                end
                e.st_en   = live;
                e.st_addr = addr;
                e.st_data = (b & keep) << (8 * addr[2:0]);
                e.st_mask = bm << addr[2:0];
            end
            op_ebreak, op_nop: ;
            default: begin
                e.wb_data = alu_ref(i.op, a, bv);
                we = 1'b1;
            end
        endcase
        e.wb_en = live && we && (i.rd != '0);
        return e;
    endfunction

    task automatic check_val(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] want);
        checks++;
        test_checks++;
        if (got !== want) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED %s: got %h, expected %h (pc %h, op %s)",
                     name, got, want, inst.pc, inst.op.name());
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 32; r++) begin
                ref_regs[r] = '0;
            end
            ref_halt = 1'b0;
            ref_code = 1'b0;
        end else begin
            exp_q = ref_exec(inst);
            if (inst.valid) begin
                check_val("dnpc", dnpc, exp_q.dnpc);
            end
            check_val("wb.en", 64'(wb.en), 64'(exp_q.wb_en));
            if (exp_q.wb_en) begin
                check_val("wb.rd", 64'(wb.rd), 64'(inst.rd));
                check_val("wb.data", wb.data, exp_q.wb_data);
            end
            check_val("mem_ren", 64'(mem_ren), 64'(exp_q.ld_en));
            if (exp_q.ld_en) begin
                check_val("mem_raddr", mem_raddr, exp_q.ld_addr);
            end
            check_val("mem_wen", 64'(mem_wen), 64'(exp_q.st_en));
            if (exp_q.st_en) begin
                check_val("mem_waddr", mem_waddr, exp_q.st_addr);
                check_val("mem_wdata", mem_wdata, exp_q.st_data);
                check_val("mem_wmask", 64'(mem_wmask), 64'(exp_q.st_mask));
            end
            check_val("halt", 64'(halt), 64'(ref_halt));
            check_val("halt_code", 64'(halt_code), 64'(ref_code));
            // model state after the coming edge
            if (exp_q.wb_en) begin
                ref_regs[inst.rd] = exp_q.wb_data;
            end
            for (int k = 0; k < mask_w; k++) begin
                if (exp_q.st_en && exp_q.st_mask[k]) begin
                    ref_mem[exp_q.st_addr[10:3]][8*k +: 8] = exp_q.st_data[8*k +: 8];
                end
            end
            if (inst.valid && !ref_halt && inst.op == op_ebreak) begin
                ref_code = (ref_regs[reg_a0] != '0);
                ref_halt = 1'b1;
            end
        end
    end

    task automatic issue(input exu_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [xlen-1:0] imm);
        logic [xlen-1:0] pc;
        pc = rand64();
        pc[1:0] = 2'b00;
        @(posedge clk);
        #5;
        inst.valid = 1'b1;
        inst.pc    = pc;
        inst.op    = op;
        inst.rd    = rd;
        inst.rs1   = rs1;
        inst.rs2   = rs2;
        inst.imm   = imm;
    endtask

    task automatic start_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        #5;
        inst = idle_inst();
        tests_done++;
        $display("%s done, %0d checks, %0d errors", name, test_checks, test_errors);
    endtask

    task automatic do_reset();
        @(posedge clk);
        #5;
        rst_n = 1'b0;
        inst  = idle_inst();
        repeat (16) @(posedge clk);
        #5;
        rst_n = 1'b1;
    endtask

    task automatic after_halt();
        issue(op_addi, 5'd11, 5'd0, 5'd0, rand64());
        issue(op_sd, 5'd0, 5'd0, 5'd11, 64'h40);
        issue(op_ld, 5'd12, 5'd0, 5'd0, 64'h40);
        issue(op_jal, 5'd1, 5'd0, 5'd0, 64'h10);
    endtask

    initial begin
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] fill;
        void'($urandom(seed));
        rst_n  = 1'b0;
        inst   = idle_inst();
        checks = 0;
        errors = 0;
        tests_done = 0;
        for (int w = 0; w < mem_words; w++) begin
            fill = (64'h9e3779b97f4a7c15 * 64'(w + 1)) ^ {32'(w), ~32'(w)};
            ext_mem[w] <= fill;
            ref_mem[w] = fill;
        end
        repeat (16) @(posedge clk);
        #5;
        rst_n = 1'b1;

        start_test();
        for (int r = 1; r < 32; r++) begin
            issue(op_addi, 5'(r), 5'd0, 5'd0, rand64());
        end
        for (int n = 0; n < n_alu; n++) begin
            issue(alu_ops[$urandom_range(27, 0)], rand_reg(1), rand_reg(0), rand_reg(0),
                  rand64());
        end
        end_test("alu ops");

        start_test();
        for (int n = 0; n < 8; n++) begin
            issue(alu_ops[$urandom_range(27, 0)], 5'd0, rand_reg(0), rand_reg(0), rand64());
        end
        issue(op_add, 5'd7, 5'd0, 5'd0, rand64());
        end_test("x0 writes");

        start_test();
        for (int n = 0; n < n_branch; n++) begin
            rs1 = rand_reg(0);
            rs2 = ($urandom_range(3, 0) == 0) ? rs1 : rand_reg(0);
            issue(br_ops[$urandom_range(7, 0)], rand_reg(1), rs1, rs2, rand64());
        end
        end_test("branches and jumps");

        start_test();
        issue(op_addi, 5'd5, 5'd0, 5'd0, 64'h100);
        issue(op_addi, 5'd9, 5'd0, 5'd0, rand64());
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off <= 8 - st_bytes[s]; off++) begin
                issue(st_ops[s], 5'd0, 5'd5, 5'd9, 64'(off));
                issue(op_ld, 5'd6, 5'd5, 5'd0, 64'd0);
            end
        end
        end_test("stores");

        start_test();
        issue(op_addi, 5'd5, 5'd0, 5'd0, 64'h200);
        // destinations above the base register keep the address intact
        for (int s = 0; s < 7; s++) begin
            for (int off = 0; off <= 8 - ld_bytes[s]; off++) begin
                issue(ld_ops[s], rand_reg(6), 5'd5, 5'd0, 64'(off));
            end
        end
        end_test("loads");

        start_test();
        issue(op_addi, reg_a0, 5'd0, 5'd0, 64'd0);
        issue(op_ebreak, 5'd0, 5'd0, 5'd0, 64'd0);
        after_halt();
        do_reset();
        issue(op_addi, reg_a0, 5'd0, 5'd0, rand64() | 64'd1);
        issue(op_ebreak, 5'd0, 5'd0, 5'd0, 64'd0);
        after_halt();
        end_test("ebreak halt");

        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/exu_pkg.sv
src/exu_ctrl.sv
src/exu_regfile.sv
src/exu_alu.sv
src/exu_lsu_align.sv
src/exu_npc.sv
src/exu_top.sv
verif/exu_checker.sv
verif/exu_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := exu_tb
LINT_TOP   := exu_top
FILELIST   := vlog.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
SOURCES    := $(wildcard src/*.sv verif/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
